/* hw/lsuPkg.sv */
package lsuPkg;

    //////////////////////////////
    // widths and sizes
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W = DATA_W / 8;
    localparam int SQN_W = 6;
    localparam int TAG_W = 6;
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);
    localparam int MEM_WAIT = 2;
    localparam int WAIT_W = $clog2(MEM_WAIT + 1);

    typedef enum logic [2:0] {
        MEMC_NONE,
        MEMC_READ_BYTE,
        MEMC_READ_HALF,
        MEMC_READ_WORD,
        MEMC_WRITE_BYTE,
        MEMC_WRITE_HALF,
        MEMC_WRITE_WORD
    } MemcCmd;

    //////////////////////////////
    // micro-ops from issue
    typedef struct packed {
        logic valid;
        logic [ADDR_W-1:0] addr;
        logic [1:0] size;           // 0 byte, 1 half, 2 word
        logic signExtend;
        logic external;             // not speculative, never flushed
        logic [SQN_W-1:0] sqN;
        logic [TAG_W-1:0] tagDst;
    } LD_UOp;

    typedef struct packed {
        logic valid;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;    // value at bit 0, lanes picked by wmask
        logic [SEL_W-1:0] wmask;
    } ST_UOp;

    typedef struct packed {
        logic taken;
        logic [SQN_W-1:0] sqN;
    } BranchProv;

    //////////////////////////////
    // memory controller
    typedef struct packed {
        MemcCmd cmd;
        logic [ADDR_W-1:0] extAddr;
        logic [DATA_W-1:0] data;
    } MemController_Req;

    typedef struct packed {
        logic valid;
        logic [DATA_W-1:0] data;    // already shifted down to bit 0
    } MemLdRes;

    typedef struct packed {
        logic valid;
    } MemStRes;

    typedef struct packed {
        MemLdRes sglLdRes;
        MemStRes sglStRes;
    } MemController_Res;

    //////////////////////////////
    // wishbone classic
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [ADDR_W-1:0] adr;
        logic [SEL_W-1:0] sel;
        logic [DATA_W-1:0] datW;
    } WbMaster;

    typedef struct packed {
        logic ack;
        logic [DATA_W-1:0] datR;
    } WbSlave;

endpackage

/* hw/uopSkidReg.sv */
module uopSkidReg #(
    parameter type T = lsuPkg::LD_UOp
) (
    input  logic clk,
    input  logic rst,

    input  logic en,
    input  T     uopIn,
    output logic inStall,

    input  logic take,
    output T     uopOut
);

    logic accept;

    // full and not drained this cycle
    assign inStall = uopOut.valid && !take;
    assign accept = en && uopIn.valid && !inStall;

    always_ff @(posedge clk) begin
        if (rst) begin
            uopOut.valid <= 1'b0;
        end else if (accept) begin
            uopOut <= uopIn;            // also refills on a take
        end else if (take) begin
            uopOut.valid <= 1'b0;
        end
    end

endmodule

/* hw/bypassLsu.sv */
module bypassLsu (
    input  logic clk,
    input  logic rst,

    input  lsuPkg::BranchProv branch,

    input  lsuPkg::LD_UOp uopLd,
    output logic takeLd,

    input  lsuPkg::ST_UOp uopSt,
    output logic takeSt,

    input  logic ldStall,
    output lsuPkg::LD_UOp uopLdOut,
    output logic [lsuPkg::DATA_W-1:0] ldData,

    output lsuPkg::MemController_Req memcReq,
    input  lsuPkg::MemController_Res memcRes
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_LD,
        WAIT_ST
    } LsuState;

    LsuState state;
    lsuPkg::LD_UOp activeLd;

    logic canAccept;
    logic ldKeep;
    logic activeFlush;
    lsuPkg::MemcCmd stCmd;
    lsuPkg::MemcCmd ldCmd;
    logic [1:0] stOff;

    // younger than a taken branch and still speculative
    function automatic logic flushedBy(lsuPkg::BranchProv br, logic ext,
                                       logic [lsuPkg::SQN_W-1:0] sqN);
        return br.taken && !ext && ($signed(sqN - br.sqN) > 0);
    endfunction

    function automatic logic [lsuPkg::DATA_W-1:0] extend(logic [lsuPkg::DATA_W-1:0] d,
                                                         logic [1:0] size, logic sx);
        logic [lsuPkg::DATA_W-1:0] r;
        case (size)
            2'd0: r = {{(lsuPkg::DATA_W - 8){sx && d[7]}}, d[7:0]};
            2'd1: r = {{(lsuPkg::DATA_W - 16){sx && d[15]}}, d[15:0]};
            default: r = d;
        endcase
        return r;
    endfunction

    //////////////////////////////
    // arbitration, store first
    always_comb begin
        canAccept = (state == IDLE) && !uopLdOut.valid;
        takeSt = canAccept && uopSt.valid;
        takeLd = canAccept && uopLd.valid && !uopSt.valid;
        ldKeep = !flushedBy(branch, uopLd.external, uopLd.sqN);
        activeFlush = flushedBy(branch, activeLd.external, activeLd.sqN);

        // lowest written lane
        stOff = 2'd0;
        for (int i = lsuPkg::SEL_W - 1; i >= 0; i--) begin
            if (uopSt.wmask[i]) begin
                stOff = 2'(i);
            end
        end

        case (uopSt.wmask)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: stCmd = lsuPkg::MEMC_WRITE_BYTE;
            4'b0011, 4'b1100: stCmd = lsuPkg::MEMC_WRITE_HALF;
            default: stCmd = lsuPkg::MEMC_WRITE_WORD;   // bad masks become word
        endcase

        case (uopLd.size)
            2'd0: ldCmd = lsuPkg::MEMC_READ_BYTE;
            2'd1: ldCmd = lsuPkg::MEMC_READ_HALF;
            default: ldCmd = lsuPkg::MEMC_READ_WORD;
        endcase
    end

    //////////////////////////////
    // FSM and result register
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            activeLd.valid <= 1'b0;
            uopLdOut.valid <= 1'b0;
            memcReq.cmd <= lsuPkg::MEMC_NONE;
        end else begin
            memcReq.cmd <= lsuPkg::MEMC_NONE;   // one cycle pulse

            if (uopLdOut.valid && !ldStall) begin
                uopLdOut.valid <= 1'b0;
            end
            if (state == WAIT_LD && activeFlush) begin
                activeLd.valid <= 1'b0;         // bus cycle still completes
            end

            case (state)
                IDLE: begin
                    if (takeSt) begin
                        memcReq.cmd <= stCmd;
                        memcReq.extAddr <= {uopSt.addr[lsuPkg::ADDR_W-1:2], stOff};
                        memcReq.data <= uopSt.data;
                        state <= WAIT_ST;
                    end else if (takeLd && ldKeep) begin
                        memcReq.cmd <= ldCmd;
                        memcReq.extAddr <= uopLd.addr;
                        activeLd <= uopLd;
                        state <= WAIT_LD;
                    end
                end
                WAIT_LD: begin
                    if (memcRes.sglLdRes.valid) begin
                        if (activeLd.valid && !activeFlush) begin
                            uopLdOut <= activeLd;
                            ldData <= extend(memcRes.sglLdRes.data, activeLd.size,
                                             activeLd.signExtend);
                        end
                        state <= IDLE;
                    end
                end
                WAIT_ST: begin
                    if (memcRes.sglStRes.valid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* hw/memcWishbone.sv */
module memcWishbone (
    input  logic clk,
    input  logic rst,

    input  lsuPkg::MemController_Req memcReq,
    output lsuPkg::MemController_Res memcRes,

    output lsuPkg::WbMaster wbM,
    input  lsuPkg::WbSlave wbS
);

    lsuPkg::MemcCmd curCmd;
    logic [1:0] curOff;

    logic reqWrite;
    logic [lsuPkg::SEL_W-1:0] reqSel;
    logic [lsuPkg::DATA_W-1:0] reqLanes;
    logic [lsuPkg::DATA_W-1:0] rdShift;
    logic [lsuPkg::DATA_W-1:0] rdData;

    //////////////////////////////
    // lane mapping
    always_comb begin
        reqSel = '1;
        reqLanes = memcReq.data;
        case (memcReq.cmd)
            lsuPkg::MEMC_READ_BYTE, lsuPkg::MEMC_WRITE_BYTE: begin
                reqSel = lsuPkg::SEL_W'(1) << memcReq.extAddr[1:0];
                reqLanes = {4{memcReq.data[7:0]}};      // byte on every lane
            end
            lsuPkg::MEMC_READ_HALF, lsuPkg::MEMC_WRITE_HALF: begin
                reqSel = memcReq.extAddr[1] ? 4'b1100 : 4'b0011;
                reqLanes = {2{memcReq.data[15:0]}};
            end
            default: ;
        endcase

        reqWrite = memcReq.cmd inside {lsuPkg::MEMC_WRITE_BYTE, lsuPkg::MEMC_WRITE_HALF,
                                       lsuPkg::MEMC_WRITE_WORD};

        // read lanes down to bit 0
        rdShift = wbS.datR >> {curOff, 3'b000};
        case (curCmd)
            lsuPkg::MEMC_READ_BYTE: rdData = {{(lsuPkg::DATA_W - 8){1'b0}}, rdShift[7:0]};
            lsuPkg::MEMC_READ_HALF: rdData = {{(lsuPkg::DATA_W - 16){1'b0}}, rdShift[15:0]};
            default: rdData = wbS.datR;
        endcase
    end

    //////////////////////////////
    // bus cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            wbM.cyc <= 1'b0;
            wbM.stb <= 1'b0;
            memcRes.sglLdRes.valid <= 1'b0;
            memcRes.sglStRes.valid <= 1'b0;
        end else begin
            memcRes.sglLdRes.valid <= 1'b0;
            memcRes.sglStRes.valid <= 1'b0;

            if (!wbM.cyc) begin
                if (memcReq.cmd != lsuPkg::MEMC_NONE) begin
                    wbM.cyc <= 1'b1;
                    wbM.stb <= 1'b1;
                    wbM.we <= reqWrite;
                    wbM.adr <= {memcReq.extAddr[lsuPkg::ADDR_W-1:2], 2'b00};
                    wbM.sel <= reqSel;
                    wbM.datW <= reqLanes;
                    curCmd <= memcReq.cmd;
                    curOff <= memcReq.extAddr[1:0];
                end
            end else if (wbS.ack) begin
                wbM.cyc <= 1'b0;
                wbM.stb <= 1'b0;
                if (wbM.we) begin
                    memcRes.sglStRes.valid <= 1'b1;
                end else begin
                    memcRes.sglLdRes.valid <= 1'b1;
                    memcRes.sglLdRes.data <= rdData;
                end
            end
        end
    end

endmodule

/* hw/wbSram.sv */
module wbSram (
    input  logic clk,
    input  logic rst,

    input  lsuPkg::WbMaster wbM,
    output lsuPkg::WbSlave wbS
);

    logic [lsuPkg::DATA_W-1:0] mem [lsuPkg::MEM_WORDS];

    logic [lsuPkg::WAIT_W-1:0] waitCnt;
    logic ackReg;
    logic [lsuPkg::DATA_W-1:0] datReg;
    logic [lsuPkg::MEM_IDX_W-1:0] idx;
    logic busy;
    logic fire;

    assign idx = wbM.adr[2 +: lsuPkg::MEM_IDX_W];   // wraps at depth
    assign busy = wbM.cyc && wbM.stb;
    assign fire = busy && !ackReg && (waitCnt == lsuPkg::WAIT_W'(lsuPkg::MEM_WAIT - 1));
    assign wbS = '{ack: ackReg, datR: datReg};

    // wait states
    always_ff @(posedge clk) begin
        if (rst) begin
            ackReg <= 1'b0;
            waitCnt <= '0;
        end else begin
            ackReg <= fire;
            if (fire || !busy) begin
                waitCnt <= '0;
            end else if (!ackReg) begin
                waitCnt <= waitCnt + 1'b1;
            end
        end
    end

    //////////////////////////////
    // array access
    always_ff @(posedge clk) begin
        if (fire) begin
            datReg <= mem[idx];
            if (wbM.we) begin
                for (int i = 0; i < lsuPkg::SEL_W; i++) begin
                    if (wbM.sel[i]) begin
                        mem[idx][8*i +: 8] <= wbM.datW[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

/* hw/lsuTop.sv */
module lsuTop (
    input  logic clk,
    input  logic rst,

    input  lsuPkg::BranchProv branch,

    input  logic ldEn,
    input  lsuPkg::LD_UOp uopLd,
    output logic ldInStall,

    input  logic stEn,
    input  lsuPkg::ST_UOp uopSt,
    output logic stInStall,

    input  logic ldStall,
    output lsuPkg::LD_UOp uopLdOut,
    output logic [lsuPkg::DATA_W-1:0] ldData
);

    lsuPkg::LD_UOp ldHeld;
    lsuPkg::ST_UOp stHeld;
    logic takeLd;
    logic takeSt;

    lsuPkg::MemController_Req memcReq;
    lsuPkg::MemController_Res memcRes;
    lsuPkg::WbMaster wbM;
    lsuPkg::WbSlave wbS;

    //////////////////////////////
    // input stages
    uopSkidReg #(.T(lsuPkg::LD_UOp)) ldStage (
        .clk    (clk),
        .rst    (rst),
        .en     (ldEn),
        .uopIn  (uopLd),
        .inStall(ldInStall),
        .take   (takeLd),
        .uopOut (ldHeld)
    );

    uopSkidReg #(.T(lsuPkg::ST_UOp)) stStage (
        .clk    (clk),
        .rst    (rst),
        .en     (stEn),
        .uopIn  (uopSt),
        .inStall(stInStall),
        .take   (takeSt),
        .uopOut (stHeld)
    );

    bypassLsu lsu (
        .clk     (clk),
        .rst     (rst),
        .branch  (branch),
        .uopLd   (ldHeld),
        .takeLd  (takeLd),
        .uopSt   (stHeld),
        .takeSt  (takeSt),
        .ldStall (ldStall),
        .uopLdOut(uopLdOut),
        .ldData  (ldData),
        .memcReq (memcReq),
        .memcRes (memcRes)
    );

    //////////////////////////////
    // controller and memory
    memcWishbone memc (
        .clk    (clk),
        .rst    (rst),
        .memcReq(memcReq),
        .memcRes(memcRes),
        .wbM    (wbM),
        .wbS    (wbS)
    );

    wbSram sram (
        .clk(clk),
        .rst(rst),
        .wbM(wbM),
        .wbS(wbS)
    );

endmodule

/* verif/lsuTbModel.svh */
`ifndef LSU_TB_MODEL_SVH
`define LSU_TB_MODEL_SVH

//////////////////////////////
// shadow memory, written as stores are issued
logic [lsuPkg::DATA_W-1:0] shadow [lsuPkg::MEM_WORDS];

// start value of a word, every address bit counts
function automatic logic [lsuPkg::DATA_W-1:0] fillWord(int word);
    logic [31:0] a;
    a = 32'(word) << 2;
    return (a * 32'h9E3779B1) ^ {a[15:0], ~a[15:0]};
endfunction

// younger than the branch and speculative
function automatic logic flushes(lsuPkg::BranchProv br, logic ext,
                                 logic [lsuPkg::SQN_W-1:0] sqN);
    logic [lsuPkg::SQN_W-1:0] diff;
    diff = sqN - br.sqN;
    return br.taken && !ext && !diff[lsuPkg::SQN_W-1] && (diff != '0);
endfunction

// lanes take store data from bit 0 upward, starting at the lowest set lane
function automatic void applyStore(lsuPkg::ST_UOp st);
    int word;
    int low;
    word = st.addr[2 +: lsuPkg::MEM_IDX_W];
    low = -1;
    for (int i = 0; i < lsuPkg::SEL_W; i++) begin
        if (st.wmask[i] && low < 0) begin
            low = i;
        end
    end
    for (int i = 0; i < lsuPkg::SEL_W; i++) begin
        if (st.wmask[i]) begin
            shadow[word][8*i +: 8] = st.data[8*(i - low) +: 8];
        end
    end
endfunction

//////////////////////////////
// expected load value
function automatic logic [lsuPkg::DATA_W-1:0] expectedLoad(logic [lsuPkg::ADDR_W-1:0] addr,
                                                           logic [1:0] size, logic sx);
    logic [31:0] w;
    logic [7:0] b;
    logic [15:0] h;
    w = shadow[addr[2 +: lsuPkg::MEM_IDX_W]];
    b = w[8*addr[1:0] +: 8];
    h = addr[1] ? w[31:16] : w[15:0];     // aligned halves only
    case (size)
        2'd0: return {{24{sx & b[7]}}, b};
        2'd1: return {{16{sx & h[15]}}, h};
        default: return w;
    endcase
endfunction

`endif

/* verif/lsuTb.sv */
module lsuTb;

    typedef struct packed {
        logic [lsuPkg::TAG_W-1:0] tag;
        logic [lsuPkg::DATA_W-1:0] value;
        logic [lsuPkg::MEM_IDX_W-1:0] word;
        logic [lsuPkg::SQN_W-1:0] sqN;
        logic external;
    } ExpectedLoad;

    logic clk;
    logic rst;
    lsuPkg::BranchProv branch;
    logic ldEn;
    lsuPkg::LD_UOp uopLd;
    logic ldInStall;
    logic stEn;
    lsuPkg::ST_UOp uopSt;
    logic stInStall;
    logic ldStall;
    lsuPkg::LD_UOp uopLdOut;
    logic [lsuPkg::DATA_W-1:0] ldData;

    integer seed = 32'h41748594;
    ExpectedLoad expQ [$];
    lsuPkg::LD_UOp ldPlan [$];
    lsuPkg::ST_UOp stPlan [$];
    int pendingLd [lsuPkg::MEM_WORDS];      // loads in flight per word
    logic [lsuPkg::TAG_W-1:0] tagCnt;
    logic randEn;
    logic stallMode;
    logic sawLdFull;
    int checks;
    int errors;
    int testNum;
    int checksBefore;
    int errorsBefore;

    `include "lsuTbModel.svh"

    lsuTop UUT (
        .clk      (clk),
        .rst      (rst),
        .branch   (branch),
        .ldEn     (ldEn),
        .uopLd    (uopLd),
        .ldInStall(ldInStall),
        .stEn     (stEn),
        .uopSt    (uopSt),
        .stInStall(stInStall),
        .ldStall  (ldStall),
        .uopLdOut (uopLdOut),
        .ldData   (ldData)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    //////////////////////////////
    // stimulus helpers
    task automatic tick();
        @(posedge clk);
        if (stallMode) begin
            ldStall <= ($random(seed) & 1) != 0;
        end
    endtask

    function automatic logic randomEnable();
        return !randEn || (($random(seed) & 1) != 0);
    endfunction

    function automatic logic [3:0] legalMask(int k);
        case (k)
            0: return 4'b0001;
            1: return 4'b0010;
            2: return 4'b0100;
            3: return 4'b1000;
            4: return 4'b0011;
            5: return 4'b1100;
            default: return 4'b1111;
        endcase
    endfunction

    task automatic planLoad(int word, logic [1:0] size, logic [1:0] off, logic sx,
                            logic [lsuPkg::SQN_W-1:0] sqN, logic ext);
        ldPlan.push_back('{valid: 1'b1, addr: (32'(word) << 2) | 32'(off), size: size,
                           signExtend: sx, external: ext, sqN: sqN, tagDst: tagCnt});
        tagCnt++;
    endtask

    task automatic planStore(int word, logic [3:0] mask, logic [31:0] data);
        stPlan.push_back('{valid: 1'b1, addr: 32'(word) << 2, data: data, wmask: mask});
    endtask

    task automatic randomLoad();
        int word;
        logic [1:0] size;
        logic [1:0] off;
        word = $random(seed) & 63;
        size = 2'(($random(seed) & 32'h7fff_ffff) % 3);
        off = 2'($random(seed));
        if (size == 2'd1) begin
            off[0] = 1'b0;
        end
        if (size == 2'd2) begin
            off = 2'd0;
        end
        planLoad(word, size, off, 1'($random(seed)), '0, 1'b0);
    endtask

    task automatic randomStore();
        int word;
        int k;
        word = $random(seed) & 63;
        k = ($random(seed) & 32'h7fff_ffff) % 7;
        planStore(word, legalMask(k), $random(seed));
    endtask

    task automatic acceptLoad(lsuPkg::LD_UOp ld);
        ExpectedLoad e;
        if (!flushes(branch, ld.external, ld.sqN)) begin
            e.tag = ld.tagDst;
            e.value = expectedLoad(ld.addr, ld.size, ld.signExtend);
            e.word = ld.addr[2 +: lsuPkg::MEM_IDX_W];
            e.sqN = ld.sqN;
            e.external = ld.external;
            expQ.push_back(e);
            pendingLd[e.word]++;
        end
    endtask

    // offers planned ops until all are taken; stores wait while a load to the word is out
    task automatic runPlans();
        lsuPkg::LD_UOp nxtLd;
        lsuPkg::ST_UOp nxtSt;
        logic ldOn;
        logic stOn;
        ldOn = 1'b0;
        stOn = 1'b0;
        do begin
            tick();
            if (stOn && stEn && !stInStall) begin
                applyStore(uopSt);
                stOn = 1'b0;
            end
            if (ldOn && ldEn && !ldInStall) begin
                acceptLoad(uopLd);
                ldOn = 1'b0;
            end else if (ldOn && ldInStall) begin
                sawLdFull = 1'b1;
            end
            if (stOn) begin
                nxtSt = uopSt;
            end else if (stPlan.size() > 0) begin
                nxtSt = stPlan.pop_front();
                stOn = 1'b1;
            end else begin
                nxtSt = '0;
            end
            if (ldOn) begin
                nxtLd = uopLd;
            end else if (ldPlan.size() > 0) begin
                nxtLd = ldPlan.pop_front();
                ldOn = 1'b1;
            end else begin
                nxtLd = '0;
            end
            uopSt <= nxtSt;
            stEn <= stOn && (pendingLd[nxtSt.addr[2 +: lsuPkg::MEM_IDX_W]] == 0)
                    && randomEnable();
            uopLd <= nxtLd;
            ldEn <= ldOn && randomEnable();
        end while (ldOn || stOn || ldPlan.size() > 0 || stPlan.size() > 0);
    endtask

    task automatic drain();
        int limit;
        limit = 30 * (expQ.size() + 2);
        while (expQ.size() > 0 && limit > 0) begin
            tick();
            limit--;
        end
        assert (expQ.size() == 0) else begin
            $display("%0d expected load results never arrived", expQ.size());
            errors += expQ.size();
            expQ.delete();
            foreach (pendingLd[i]) begin
                pendingLd[i] = 0;
            end
        end
    endtask

    task automatic reportTest(string name);
        testNum++;
        $display("test %0d %-8s %0d checks, %0d errors", testNum, name,
                 checks - checksBefore, errors - errorsBefore);
        checksBefore = checks;
        errorsBefore = errors;
    endtask

    //////////////////////////////
    // result checker
    task automatic compareResult(logic [lsuPkg::TAG_W-1:0] tag,
                                 logic [lsuPkg::DATA_W-1:0] data);
        ExpectedLoad e;
        checks++;
        assert (expQ.size() > 0) else begin
            $display("unexpected load result with tag %h", tag);
            errors++;
        end
        if (expQ.size() > 0) begin
            e = expQ.pop_front();
            pendingLd[e.word]--;
            assert (tag === e.tag) else begin
                $display("** Error: uopLdOut.tagDst = %h, expected %h", tag, e.tag);
                errors++;
            end
            assert (data === e.value) else begin
                $display("** Error: ldData = %h, expected %h (tag %h)", data, e.value, e.tag);
                errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst && uopLdOut.valid && !ldStall) begin
            compareResult(uopLdOut.tagDst, ldData);
        end
    end

    //////////////////////////////
    // tests
    initial begin
        lsuPkg::BranchProv held;
        rst = 1'b1;
        branch = '0;
        ldEn = 1'b0;
        uopLd = '0;
        stEn = 1'b0;
        uopSt = '0;
        ldStall = 1'b0;
        randEn = 1'b0;
        stallMode = 1'b0;
        sawLdFull = 1'b0;
        tagCnt = '0;
        checks = 0;
        errors = 0;
        testNum = 0;
        checksBefore = 0;
        errorsBefore = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        tick();

        // word stores fill the test area, then read back
        for (int w = 0; w < 64; w++) begin
            planStore(w, 4'b1111, fillWord(w));
        end
        runPlans();
        for (int w = 0; w < 64; w++) begin
            planLoad(w, 2'd2, 2'd0, 1'b0, '0, 1'b0);
        end
        runPlans();
        drain();
        reportTest("word");

        for (int k = 0; k < 6; k++) begin
            planStore(8 + k, legalMask(k), $random(seed));
            runPlans();
            for (int off = 0; off < 4; off++) begin
                planLoad(8 + k, 2'd0, 2'(off), 1'b0, '0, 1'b0);
                planLoad(8 + k, 2'd0, 2'(off), 1'b1, '0, 1'b0);
            end
            for (int off = 0; off < 4; off += 2) begin
                planLoad(8 + k, 2'd1, 2'(off), 1'b0, '0, 1'b0);
                planLoad(8 + k, 2'd1, 2'(off), 1'b1, '0, 1'b0);
            end
            planLoad(8 + k, 2'd2, 2'd0, 1'b0, '0, 1'b0);
            runPlans();
        end
        drain();
        reportTest("lanes");

        // first load is hit while it waits on the bus
        held = '{taken: 1'b1, sqN: 6'd20};
        planLoad(1, 2'd2, 2'd0, 1'b0, 6'd30, 1'b0);
        runPlans();
        tick();
        branch <= held;
        if (flushes(held, expQ[$].external, expQ[$].sqN)) begin
            pendingLd[expQ[$].word]--;
            void'(expQ.pop_back());
        end
        planStore(2, 4'b1111, 32'hC0DE_5A17);
        planLoad(3, 2'd2, 2'd0, 1'b0, 6'd10, 1'b0);
        planLoad(4, 2'd2, 2'd0, 1'b0, 6'd25, 1'b0);
        planLoad(5, 2'd2, 2'd0, 1'b0, 6'd33, 1'b1);
        planLoad(6, 2'd2, 2'd0, 1'b0, 6'd50, 1'b0);
        planLoad(7, 2'd2, 2'd0, 1'b0, 6'd60, 1'b0);    // wraps, older
        planLoad(2, 2'd2, 2'd0, 1'b0, 6'd40, 1'b1);    // reads the store
        runPlans();
        drain();
        branch <= '0;
        reportTest("flush");

        stallMode = 1'b1;
        sawLdFull = 1'b0;
        for (int n = 0; n < 40; n++) begin
            randomLoad();
        end
        runPlans();
        drain();
        stallMode = 1'b0;
        ldStall <= 1'b0;
        checks++;
        assert (sawLdFull) else begin
            $display("ldInStall never rose while the load pipeline was full");
            errors++;
        end
        reportTest("stall");

        randEn = 1'b1;
        for (int n = 0; n < 200; n++) begin
            if (($random(seed) & 1) != 0) begin
                randomStore();
            end else begin
                randomLoad();
            end
        end
        runPlans();
        drain();
        randEn = 1'b0;
        reportTest("random");

        $display("%0d tests, %0d checks, %0d errors", testNum, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    //////////////////////////////
    // watchdog
    initial begin
        int totalOps;
        totalOps = 64 * 2 + 6 * 14 + 8 + 40 + 200;     // ops issued by all tests
        #(totalOps * 20 * 40 + 16 * 40);
        $display("timeout after %0d operations' worth of cycles", totalOps);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* all.f */
+incdir+verif
hw/lsuPkg.sv
hw/uopSkidReg.sv
hw/bypassLsu.sv
hw/memcWishbone.sv
hw/wbSram.sv
hw/lsuTop.sv
verif/lsuTb.sv
